/* hdl/pea_enable.sv */
// Fire readiness check of the actor from the head command and the FIFO counts
`timescale 1ns/1ps

module pea_enable (
   input  logic                           busy,
   input  pea_pkg::command_t              head_command,
   input  logic [pea_pkg::count_size-1:0] control_pop,
   input  logic [pea_pkg::count_size-1:0] data_pop,
   input  logic [pea_pkg::count_size-1:0] result_free,
   input  logic [pea_pkg::count_size-1:0] status_free,
   output logic                           enable
);

   import pea_pkg::*;

   // Data tokens that the head command would pop
   logic [count_size:0] need;

   // Separate terms of the firing rule
   logic have_command;
   logic have_data;
   logic have_space;

   // --------------------------------------------------
   // Firing rule
   // --------------------------------------------------

   // The head token means nothing while the control FIFO is empty,
   // so have_command masks whatever need comes out of it
   assign need = data_need(head_command);

   assign have_command = (control_pop != '0);

   // The population is widened by one bit to meet the need, which may reach twice a count
   assign have_data = ({1'b0, data_pop} >= need);

   // Each firing writes exactly one result and one status token
   assign have_space = (result_free != '0) && (status_free != '0);

   // Nothing is offered while a firing is under way or its FC is pending
   assign enable = !busy && have_command && have_data && have_space;

endmodule

/* hdl/pea_fifo.sv */
// Show-ahead token FIFO with population and free space counts
`timescale 1ns/1ps

module pea_fifo #(
   parameter int width = pea_pkg::word_size,
   parameter int depth = pea_pkg::fifo_depth
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         wr,
   input  logic [width-1:0]             wr_data,
   input  logic                         rd,
   output logic [width-1:0]             head,
   output logic [pea_pkg::count_size-1:0] pop,
   output logic [pea_pkg::count_size-1:0] free
);

   import pea_pkg::*;

   // Pointer width, kept at one bit for a single entry buffer
   localparam int ptr_size = (depth > 1) ? $clog2(depth) : 1;

   // Depth and last pointer value at the widths they are compared against
   localparam logic [count_size-1:0] depth_c = count_size'(depth);
   localparam logic [ptr_size-1:0] last_ptr = ptr_size'(depth - 1);

   logic [width-1:0] mem [depth];
   logic [ptr_size-1:0] rd_ptr;
   logic [ptr_size-1:0] wr_ptr;
   logic [count_size-1:0] count;

   // --------------------------------------------------
   // Storage
   // --------------------------------------------------

   // The slot under wr_ptr is always free when a producer writes
   always_ff @(posedge clk)
   begin
      if (wr)
         mem[wr_ptr] <= wr_data;
   end

   // --------------------------------------------------
   // Pointers and occupancy
   // --------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // Pointers wrap at the last slot, so any depth works
         if (wr)
            wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
         if (rd)
            rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
         // A read and a write in the same cycle leave the count as it is
         case ({wr, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // The oldest token is visible without a read
   assign head = mem[rd_ptr];
   assign pop  = count;
   assign free = depth_c - count;

   // Producers and consumers honour the counts, so the buffer never over or under runs
   assert property (@(posedge clk) disable iff (!rst) wr |-> (free != '0));
   assert property (@(posedge clk) disable iff (!rst) rd |-> (pop != '0));

endmodule

/* hdl/pea_firing_fsm.sv */
// Firing FSM that pops a command and its data, computes, and writes result and status
`timescale 1ns/1ps

module pea_firing_fsm (
   input  logic              clk,
   input  logic              rst,
   input  logic              start,
   input  pea_pkg::command_t command_head,
   input  pea_pkg::data_t    data_head,
   output logic              control_rd,
   output logic              data_rd,
   output logic              result_wr,
   output logic              status_wr,
   output pea_pkg::result_t  result,
   output pea_pkg::status_t  status,
   output logic              done
);

   import pea_pkg::*;

   // One pass through these states is one firing
   typedef enum logic [2:0] {
      idle      = 3'd0,
      fetch_cmd = 3'd1,
      read_data = 3'd2,
      compute   = 3'd3,
      write     = 3'd4
   } state_e;

   // Smallest data token widened to a result, the starting point of MAX
   localparam result_t max_init = -32'sd32768;

   state_e state;
   command_t cmd_q;
   logic [count_size:0] need;
   logic [count_size:0] remaining;
   logic pair_second;
   data_t pair_first;
   result_t acc;
   result_t data_ext;
   result_t product;
   status_code_e code;
   result_t result_q;
   status_t status_q;
   logic [15:0] firing_index;

   // --------------------------------------------------
   // Datapath helpers
   // --------------------------------------------------

   // Need of the command at the head, read while it is being popped
   assign need = data_need(command_head);

   // Sign extension of the incoming token
   assign data_ext = data_head;

   // Signed product of the held first token and the second token of a pair
   assign product = pair_first * data_head;

   // An unknown opcode outranks an empty count
   always_comb
   begin
      if (!(cmd_q.op inside {op_sum, op_max, op_dot}))
         code = st_bad_op;
      else if (cmd_q.b == '0)
         code = st_empty_count;
      else
         code = st_ok;
   end

   // --------------------------------------------------
   // Sequencing
   // --------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         state        <= idle;
         remaining    <= '0;
         pair_second  <= 1'b0;
         firing_index <= '0;
      end
      else
      begin
         case (state)
            idle:
               if (start) state <= fetch_cmd;
            fetch_cmd:
            begin
               // Commands without data skip straight to compute
               remaining   <= need;
               pair_second <= 1'b0;
               state       <= (need == '0) ? compute : read_data;
            end
            read_data:
            begin
               remaining   <= remaining - 1'b1;
               pair_second <= !pair_second;
               if (remaining == 1) state <= compute;
            end
            compute:
               state <= write;
            write:
            begin
               // The index in the status just written belongs to this firing
               firing_index <= firing_index + 1'b1;
               state        <= idle;
            end
            default:
               state <= idle;
         endcase
      end
   end

   // --------------------------------------------------
   // Accumulation and output tokens
   // --------------------------------------------------

   always_ff @(posedge clk)
   begin
      case (state)
         fetch_cmd:
         begin
            cmd_q <= command_head;
            acc   <= (command_head.op == op_max) ? max_init : '0;
         end
         read_data:
         begin
            case (cmd_q.op)
               op_sum: acc <= acc + data_ext;
               op_max: if (data_ext > acc) acc <= data_ext;
               op_dot:
               begin
                  // First token of a pair is held until its partner arrives
                  if (pair_second)
                     acc <= acc + product;
                  else
                     pair_first <= data_head;
               end
               default: acc <= acc;
            endcase
         end
         compute:
         begin
            // Failed firings give a zero result whatever sits in acc
            if (code != st_ok)
               result_q <= '0;
            else if (cmd_q.op == op_sum)
               result_q <= acc >>> cmd_q.arg1;
            else
               result_q <= acc;
            status_q <= '{firing_index: firing_index, code: code};
         end
         default: acc <= acc;
      endcase
   end

   assign control_rd = (state == fetch_cmd);
   assign data_rd    = (state == read_data);

   // Result, status and done share the single write cycle
   assign result_wr = (state == write);
   assign status_wr = (state == write);
   assign done      = (state == write);
   assign result    = result_q;
   assign status    = status_q;

   // A start that arrives while a firing is still open would be lost
   assert property (@(posedge clk) disable iff (!rst) start |-> (state == idle));

endmodule

/* hdl/pea_invoke_ctrl.sv */
// Top level firing FSM of the actor that turns invoke into start and reports FC
`timescale 1ns/1ps

module pea_invoke_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic invoke,
   input  logic done,
   output logic start,
   output logic busy,
   output logic fc
);

   // Waits for invoke, starts the firing, then waits for its end
   typedef enum logic [1:0] {
      idle       = 2'b00,
      fire_start = 2'b01,
      fire_wait  = 2'b10
   } state_e;

   state_e state;

   // --------------------------------------------------
   // State register
   // --------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst)
         state <= idle;
      else
      begin
         case (state)
            idle:       if (invoke) state <= fire_start;
            // Start lasts a single cycle
            fire_start: state <= fire_wait;
            fire_wait:  if (done) state <= idle;
            default:    state <= idle;
         endcase
      end
   end

   // Start is high for the one cycle after invoke was taken
   assign start = (state == fire_start);
   assign busy  = (state != idle);

   // FC is the firing FSM done, seen while the firing is open
   assign fc = (state == fire_wait) && done;

   // The scheduler only invokes an enabled actor, and enable is low while busy
   assert property (@(posedge clk) disable iff (!rst) invoke |-> !busy);

   // The firing FSM ends a firing only after it was started from here
   assert property (@(posedge clk) disable iff (!rst) done |-> (state == fire_wait));

endmodule

/* hdl/pea_pkg.sv */
// Token sizes, token structs, opcode and status enums, and the data need rule of the actor
package pea_pkg;

   // --------------------------------------------------
   // Sizes
   // --------------------------------------------------

   // Width of a data token and of a command token
   localparam int word_size = 16;

   // Width of a result token and of a status token
   localparam int result_size = 32;

   // Default number of tokens that each FIFO holds
   localparam int fifo_depth = 16;

   // Width of a FIFO population or free count, wide enough to hold a full FIFO
   localparam int count_size = 5;

   // --------------------------------------------------
   // Command tokens
   // --------------------------------------------------

   // Opcodes carried in the upper byte of a command token
   typedef enum logic [7:0] {
      op_sum = 8'h01,
      op_max = 8'h02,
      op_dot = 8'h03
   } op_e;

   // Command token with the opcode on top, then the shift and the count
   typedef struct packed {
      op_e        op;
      logic [2:0] arg1;
      logic [4:0] b;
   } command_t;

   // --------------------------------------------------
   // Data, result and status tokens
   // --------------------------------------------------

   // Two's complement data token
   typedef logic signed [word_size-1:0] data_t;

   // Two's complement result token, sums wrap at this width
   typedef logic signed [result_size-1:0] result_t;

   // Outcome of one firing
   typedef enum logic [15:0] {
      st_ok          = 16'h0000,
      st_bad_op      = 16'h0001,
      st_empty_count = 16'h0002
   } status_code_e;

   // Status token with the firing number in the upper half
   typedef struct packed {
      logic [15:0]  firing_index;
      status_code_e code;
   } status_t;

   // --------------------------------------------------
   // Data need of a command
   // --------------------------------------------------

   // Number of data tokens that one firing of this command pops
   // DOT reads b pairs, so the need may reach twice the largest count
   function automatic logic [count_size:0] data_need(input command_t cmd);
      logic [count_size:0] need;
      need = '0;
      case (cmd.op)
         op_sum, op_max: need = {1'b0, cmd.b};
         op_dot:         need = {cmd.b, 1'b0};
         // Unknown opcodes pop no data at all
         default:        need = '0;
      endcase
      return need;
   endfunction

endpackage

/* hdl/pea_top.sv */
// Actor top level with four token FIFOs, the enable check, invoke control and the firing FSM
`timescale 1ns/1ps

module pea_top #(
   parameter int depth = pea_pkg::fifo_depth
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           control_wr,
   input  pea_pkg::command_t              control_token,
   input  logic                           data_wr,
   input  pea_pkg::data_t                 data_token,
   output logic [pea_pkg::count_size-1:0] control_free,
   output logic [pea_pkg::count_size-1:0] data_free,
   input  logic                           invoke,
   output logic                           enable,
   output logic                           fc,
   input  logic                           result_rd,
   input  logic                           status_rd,
   output pea_pkg::result_t               result_head,
   output pea_pkg::status_t               status_head,
   output logic [pea_pkg::count_size-1:0] result_pop,
   output logic [pea_pkg::count_size-1:0] status_pop
);

   import pea_pkg::*;

   // Input side, between the FIFOs and the firing FSM
   command_t control_head;
   data_t data_head;
   logic control_rd;
   logic data_rd;
   logic [count_size-1:0] control_pop;
   logic [count_size-1:0] data_pop;

   // Output side
   result_t result_in;
   status_t status_in;
   logic result_wr;
   logic status_wr;
   logic [count_size-1:0] result_free;
   logic [count_size-1:0] status_free;

   // Handshake between invoke control and the firing FSM
   logic busy;
   logic start;
   logic done;

   // --------------------------------------------------
   // Token FIFOs
   // --------------------------------------------------

   pea_fifo #(.width($bits(command_t)), .depth(depth)) control_fifo (
      .clk(clk), .rst(rst), .wr(control_wr), .wr_data(control_token), .rd(control_rd),
      .head(control_head), .pop(control_pop), .free(control_free));

   pea_fifo #(.width($bits(data_t)), .depth(depth)) data_fifo (
      .clk(clk), .rst(rst), .wr(data_wr), .wr_data(data_token), .rd(data_rd),
      .head(data_head), .pop(data_pop), .free(data_free));

   pea_fifo #(.width($bits(result_t)), .depth(depth)) result_fifo (
      .clk(clk), .rst(rst), .wr(result_wr), .wr_data(result_in), .rd(result_rd),
      .head(result_head), .pop(result_pop), .free(result_free));

   pea_fifo #(.width($bits(status_t)), .depth(depth)) status_fifo (
      .clk(clk), .rst(rst), .wr(status_wr), .wr_data(status_in), .rd(status_rd),
      .head(status_head), .pop(status_pop), .free(status_free));

   // --------------------------------------------------
   // Control and firing
   // --------------------------------------------------

   pea_enable enable_check (
      .busy(busy), .head_command(control_head), .control_pop(control_pop),
      .data_pop(data_pop), .result_free(result_free), .status_free(status_free),
      .enable(enable));

   pea_invoke_ctrl invoke_ctrl (
      .clk(clk), .rst(rst), .invoke(invoke), .done(done),
      .start(start), .busy(busy), .fc(fc));

   pea_firing_fsm firing_fsm (
      .clk(clk), .rst(rst), .start(start), .command_head(control_head),
      .data_head(data_head), .control_rd(control_rd), .data_rd(data_rd),
      .result_wr(result_wr), .status_wr(status_wr), .result(result_in),
      .status(status_in), .done(done));

endmodule

/* tb.f */
hdl/pea_pkg.sv
hdl/pea_fifo.sv
hdl/pea_enable.sv
hdl/pea_invoke_ctrl.sv
hdl/pea_firing_fsm.sv
hdl/pea_top.sv
tb/pea_clock_gen.sv
tb/pea_tb.sv

/* tb/pea_clock_gen.sv */
// Testbench clock of 4 ns period and an active low reset held for three cycles
`timescale 1ns/1ps

module pea_clock_gen (
   output logic clk,
   output logic rst
);

   // Half of the 4 ns period
   localparam realtime half_period = 2.0;

   initial
   begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // Reset is low from time zero and is released on the third rising edge
   initial
   begin
      rst = 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b1;
   end

endmodule

/* tb/pea_tb.sv */
// Testbench of the actor with a firing table, scheduler, producer, consumer and reference model
`timescale 1ns/1ps

module pea_tb;

   import pea_pkg::*;

   // One row of the firing table, the data values sit in a separate array
   typedef struct packed {
      command_t   cmd;
      logic [3:0] ndata;
      logic       rnd;
      logic       hold;
   } entry_t;

   localparam int table_size = 24;
   // Cycles that enable is watched while the result FIFO is full
   localparam int hold_cycles = 6;

   logic clk;
   logic rst;
   logic control_wr;
   command_t control_token;
   logic data_wr;
   data_t data_token;
   logic [count_size-1:0] control_free;
   logic [count_size-1:0] data_free;
   logic invoke;
   logic enable;
   logic fc;
   logic result_rd;
   logic status_rd;
   result_t result_head;
   status_t status_head;
   logic [count_size-1:0] result_pop;
   logic [count_size-1:0] status_pop;

   entry_t fire_table [table_size];
   data_t listed [table_size][8];
   int n_entries;
   // Model of the data FIFO, and the tokens the consumer still expects
   data_t data_q [$];
   result_t exp_result_q [$];
   status_t exp_status_q [$];
   integer seed;
   int firings;
   int cycle_count;
   int cycle_limit;

   pea_clock_gen clock_gen (.clk(clk), .rst(rst));

   pea_top UUT (
      .clk(clk), .rst(rst), .control_wr(control_wr), .control_token(control_token),
      .data_wr(data_wr), .data_token(data_token), .control_free(control_free),
      .data_free(data_free), .invoke(invoke), .enable(enable), .fc(fc),
      .result_rd(result_rd), .status_rd(status_rd), .result_head(result_head),
      .status_head(status_head), .result_pop(result_pop), .status_pop(status_pop));

   // --------------------------------------------------
   // Failure handling and checks
   // --------------------------------------------------

   task automatic abort_run;
      $display("Result: FAILED");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic check_result(input result_t got, input result_t exp);
      if (got !== exp)
      begin
         $display("Error at %0t ns: result %0d, expected %0d", $time, got, exp);
         abort_run();
      end
   endtask

   task automatic check_status(input status_t got, input status_t exp);
      if (got !== exp)
      begin
         $display("Error at %0t ns: status index %0d code %0d, expected index %0d code %0d",
                  $time, got.firing_index, got.code, exp.firing_index, exp.code);
         abort_run();
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input string what, input logic [count_size-1:0] got,
                              input logic [count_size-1:0] exp);
      if (got !== exp)
      begin
         $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_latency(input int got, input int exp);
      if (got != exp)
      begin
         $display("Error at %0t ns: FC after %0d cycles, expected %0d", $time, got, exp);
         abort_run();
      end
   endtask

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------

   // SUM and MAX read b tokens, DOT reads b pairs, anything else reads none
   function automatic int tokens_needed(input command_t c);
      if (c.op == op_sum || c.op == op_max)
         return int'(c.b);
      if (c.op == op_dot)
         return 2 * int'(c.b);
      return 0;
   endfunction

   task automatic model_firing(input command_t c, output result_t r, output status_t s);
      int i;
      result_t acc;
      result_t first;
      result_t tok;
      acc = '0;
      first = '0;
      s.firing_index = firings[15:0];
      if (!(c.op == op_sum || c.op == op_max || c.op == op_dot))
         s.code = st_bad_op;
      else if (c.b == '0)
         s.code = st_empty_count;
      else
         s.code = st_ok;
      for (i = 0; i < tokens_needed(c); i++)
      begin
         tok = data_q.pop_front();
         if (c.op == op_sum)
            acc = acc + tok;
         else if (c.op == op_max)
         begin
            if (i == 0 || tok > acc)
               acc = tok;
         end
         else if (i % 2 == 0)
            first = tok;
         else
            acc = acc + first * tok;
      end
      // Sums wrap at 32 bits and only SUM is shifted
      if (s.code != st_ok)
         r = '0;
      else if (c.op == op_sum)
         r = acc >>> c.arg1;
      else
         r = acc;
      firings++;
   endtask

   // --------------------------------------------------
   // Producer, scheduler and consumer
   // --------------------------------------------------

   // Every earlier command has fired, so the control FIFO is empty here
   task automatic send_command(input command_t c);
      @(negedge clk);
      check_count("control free", control_free, count_size'(fifo_depth));
      while (control_free == '0)
         @(negedge clk);
      @(posedge clk);
      control_wr <= 1'b1;
      control_token <= c;
      @(posedge clk);
      control_wr <= 1'b0;
   endtask

   // A write still in flight uses one credit, so it is taken off the free count
   task automatic send_data(input data_t d, input int need);
      @(negedge clk);
      check_count("data free", data_free,
                  count_size'(fifo_depth - int'(data_q.size()) + int'(data_wr)));
      while (data_free <= data_wr)
      begin
         @(posedge clk);
         data_wr <= 1'b0;
         @(negedge clk);
      end
      if (int'(data_q.size()) - int'(data_wr) < need)
         check_flag("enable while data is short", enable, 1'b0);
      @(posedge clk);
      data_wr <= 1'b1;
      data_token <= d;
      data_q.push_back(d);
   endtask

   // Reads every expected token back to back, the head is checked in the cycle it leaves
   task automatic drain_outputs;
      int n;
      n = exp_result_q.size();
      @(negedge clk);
      check_count("result population", result_pop, count_size'(n));
      check_count("status population", status_pop, count_size'(n));
      if (n > 0)
      begin
         @(posedge clk);
         result_rd <= 1'b1;
         status_rd <= 1'b1;
         repeat (n)
         begin
            @(negedge clk);
            check_result(result_head, exp_result_q.pop_front());
            check_status(status_head, exp_status_q.pop_front());
            @(posedge clk);
         end
         result_rd <= 1'b0;
         status_rd <= 1'b0;
      end
   endtask

   // Waits for enable, invokes once and counts the cycles up to FC
   task automatic fire(input int need);
      int cycles;
      logic fc_seen;
      @(negedge clk);
      if (result_pop == count_size'(fifo_depth))
      begin
         // A full result FIFO must keep the scheduler from invoking
         repeat (hold_cycles)
         begin
            check_flag("enable with full result FIFO", enable, 1'b0);
            @(negedge clk);
         end
         drain_outputs();
         @(negedge clk);
      end
      while (!enable)
         @(negedge clk);
      @(posedge clk);
      invoke <= 1'b1;
      @(posedge clk);
      invoke <= 1'b0;
      cycles = 0;
      fc_seen = 1'b0;
      while (!fc_seen)
      begin
         @(negedge clk);
         fc_seen = fc;
         check_flag("enable during a firing", enable, 1'b0);
         @(posedge clk);
         cycles++;
      end
      check_latency(cycles, need + 4);
   endtask

   task automatic apply_entry(input int e);
      command_t c;
      int need;
      int k;
      data_t d;
      result_t r;
      status_t s;
      c = fire_table[e].cmd;
      need = tokens_needed(c);
      // Command first, so enable has to wait for the data
      send_command(c);
      for (k = 0; k < int'(fire_table[e].ndata); k++)
      begin
         if (fire_table[e].rnd)
            d = data_t'($random(seed));
         else
            d = listed[e][k];
         send_data(d, need);
      end
      if (fire_table[e].ndata != '0)
      begin
         @(posedge clk);
         data_wr <= 1'b0;
      end
      fire(need);
      model_firing(c, r, s);
      exp_result_q.push_back(r);
      exp_status_q.push_back(s);
      if (!fire_table[e].hold)
         drain_outputs();
   endtask

   // --------------------------------------------------
   // Firing table
   // --------------------------------------------------

   task automatic add_entry(input command_t c, input int ndata, input logic rnd,
                            input logic hold);
      fire_table[n_entries] = '{cmd: c, ndata: ndata[3:0], rnd: rnd, hold: hold};
      n_entries++;
   endtask

   task automatic build_table;
      int i;
      command_t c;
      n_entries = 0;
      // Shifted SUM over listed values with negatives
      add_entry('{op_sum, 3'd1, 5'd4}, 4, 1'b0, 1'b0);
      listed[0] = '{100, -7, -250, 33, 0, 0, 0, 0};
      add_entry('{op_max, 3'd0, 5'd5}, 5, 1'b1, 1'b0);
      add_entry('{op_dot, 3'd0, 5'd3}, 6, 1'b1, 1'b0);
      // The tokens written with these two belong to the SUM after them
      add_entry('{op_e'(8'h7e), 3'd2, 5'd3}, 2, 1'b0, 1'b0);
      listed[3] = '{5, -9, 0, 0, 0, 0, 0, 0};
      add_entry('{op_sum, 3'd0, 5'd0}, 1, 1'b0, 1'b0);
      listed[4] = '{12, 0, 0, 0, 0, 0, 0, 0};
      add_entry('{op_sum, 3'd0, 5'd4}, 1, 1'b0, 1'b0);
      listed[5] = '{-1000, 0, 0, 0, 0, 0, 0, 0};
      add_entry('{op_dot, 3'd0, 5'd0}, 0, 1'b0, 1'b0);
      // Sixteen firings without a consumer fill the result FIFO
      for (i = 0; i < fifo_depth; i++)
      begin
         c.op = (i % 3 == 0) ? op_sum : (i % 3 == 1) ? op_max : op_dot;
         c.arg1 = 3'(i % 8);
         c.b = 5'(1 + i % 4);
         add_entry(c, tokens_needed(c), 1'b1, 1'b1);
      end
      add_entry('{op_max, 3'd0, 5'd2}, 2, 1'b1, 1'b0);
   endtask

   // --------------------------------------------------
   // Run control
   // --------------------------------------------------

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count > cycle_limit)
      begin
         $display("Timeout: the run did not end within %0d cycles", cycle_limit);
         abort_run();
      end
   end

   initial
   begin
      int e;
      control_wr = 1'b0;
      control_token = '0;
      data_wr = 1'b0;
      data_token = '0;
      invoke = 1'b0;
      result_rd = 1'b0;
      status_rd = 1'b0;
      seed = 32'hdff6_4a6c;
      firings = 0;
      cycle_count = 0;
      build_table();
      cycle_limit = 20;
      for (e = 0; e < n_entries; e++)
         cycle_limit += 2 * tokens_needed(fire_table[e].cmd) + 12;
      @(negedge clk);
      while (!rst)
         @(negedge clk);
      check_flag("enable after reset", enable, 1'b0);
      check_flag("FC after reset", fc, 1'b0);
      for (e = 0; e < n_entries; e++)
         apply_entry(e);
      $display("Result: PASSED");
      $finish;
   end

endmodule
